// File: files.f
+incdir+logic
logic/enc_pkg.sv
logic/sample_framer.sv
logic/frame_peak_meter.sv
logic/frame_record_packer.sv
logic/enc_apb_regs.sv
logic/audio_frame_encoder_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// File: logic/audio_frame_encoder_top.sv
// encoder top, framer, peak meter, record packer and register block
`timescale 1ns/1ps
`include "enc_consts.svh"

module audio_frame_encoder_top (
    input  logic               clk,
    input  logic               rst_n,
    // audio sample stream
    input  logic               audio_tvalid,
    input  logic [31:0]        audio_tdata,
    input  logic               audio_tlast,
    output logic               audio_tready,
    // record byte stream
    output logic               bs_tvalid,
    output enc_pkg::byte_t     bs_tdata,
    output logic               bs_tlast,
    output logic [15:0]        bs_tuser,
    input  logic               bs_tready,
    // register bus
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  enc_pkg::reg_addr_t paddr,
    input  enc_pkg::reg_word_t pwdata,
    output enc_pkg::reg_word_t prdata,
    output logic               pready,
    output logic               pslverr,
    // status
    output logic               encoding_active,
    output logic               frame_processing,
    output enc_pkg::reg_word_t error_status
);
    import enc_pkg::*;

    logic    ctrl_enable;
    logic    packer_busy;
    logic    sample_accept;
    logic    frame_end;
    logic    frame_done;
    logic    frame_active;
    logic    overlength;
    logic    record_sent;
    count_t  frame_count;
    sample_t frame_peak;

    assign encoding_active  = packer_busy;
    assign frame_processing = frame_active;

    sample_framer sample_framer_inst (
        .clk(clk), .rst_n(rst_n), .ctrl_enable(ctrl_enable), .packer_busy(packer_busy),
        .audio_tvalid(audio_tvalid), .audio_tlast(audio_tlast), .audio_tready(audio_tready),
        .sample_accept(sample_accept), .frame_end(frame_end), .frame_done(frame_done),
        .frame_count(frame_count), .frame_active(frame_active), .overlength(overlength)
    );

    frame_peak_meter frame_peak_meter_inst (
        .clk(clk), .rst_n(rst_n), .sample_accept(sample_accept), .frame_end(frame_end),
        .audio_tdata(audio_tdata[`SAMPLE_W-1:0]), .frame_peak(frame_peak)
    );

    frame_record_packer frame_record_packer_inst (
        .clk(clk), .rst_n(rst_n), .frame_done(frame_done), .frame_count(frame_count),
        .frame_peak(frame_peak), .bs_tready(bs_tready), .bs_tvalid(bs_tvalid),
        .bs_tdata(bs_tdata), .bs_tlast(bs_tlast), .bs_tuser(bs_tuser),
        .packer_busy(packer_busy), .record_sent(record_sent)
    );

    enc_apb_regs enc_apb_regs_inst (
        .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .packer_busy(packer_busy),
        .record_sent(record_sent), .overlength(overlength), .prdata(prdata),
        .pready(pready), .pslverr(pslverr), .ctrl_enable(ctrl_enable),
        .error_status(error_status)
    );

endmodule

// File: logic/enc_apb_regs.sv
// APB register block with control, status, error and version registers
`timescale 1ns/1ps
`include "enc_consts.svh"

module enc_apb_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  enc_pkg::reg_addr_t  paddr,
    input  enc_pkg::reg_word_t  pwdata,
    input  logic                packer_busy,
    input  logic                record_sent,
    input  logic                overlength,
    output enc_pkg::reg_word_t  prdata,
    output logic                pready,
    output logic                pslverr,
    output logic                ctrl_enable,
    output enc_pkg::reg_word_t  error_status
);
    import enc_pkg::*;

    logic [15:0] rec_cnt;
    logic        err_overlength;
    logic        access_start;
    logic        access_done;
    logic        addr_mapped;
    logic        err_clear;
    reg_word_t   rd_mux;

    // one wait state, pready answers the first access cycle
    assign access_start = psel && penable && !pready;
    assign access_done  = psel && penable && pready;
    assign err_clear    = access_done && pwrite && (paddr == `ADDR_ERROR) && pwdata[0];
    assign error_status = {31'b0, err_overlength};

    // ==========================================================
    // address decode and read mux
    // ==========================================================
    always_comb begin
        addr_mapped = 1'b1;
        rd_mux      = '0;
        case (paddr)
            `ADDR_CTRL:    rd_mux = {31'b0, ctrl_enable};
            `ADDR_STATUS:  rd_mux = {15'b0, packer_busy, rec_cnt};
            `ADDR_ERROR:   rd_mux = error_status;
            `ADDR_VERSION: rd_mux = `VERSION_WORD;
            default:       addr_mapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
            prdata  <= '0;
        end else begin
            pready  <= access_start;
            pslverr <= access_start && !addr_mapped;
            prdata  <= (access_start && !pwrite) ? rd_mux : '0;
        end
    end

    // control, record counter and sticky error
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_enable    <= 1'b0;
            rec_cnt        <= '0;
            err_overlength <= 1'b0;
        end else begin
            if (access_done && pwrite && paddr == `ADDR_CTRL) begin
                ctrl_enable <= pwdata[0];
            end
            if (record_sent) begin
                rec_cnt <= rec_cnt + 1'b1;
            end
            // a new overlength wins over a clear in the same cycle
            if (overlength) begin
                err_overlength <= 1'b1;
            end else if (err_clear) begin
                err_overlength <= 1'b0;
            end
        end
    end

endmodule

// File: logic/enc_consts.svh
// widths, register offsets, version word and record length for the frame encoder
`ifndef ENC_CONSTS_SVH
`define ENC_CONSTS_SVH

// ==========================================================
// datapath widths
// ==========================================================
`define SAMPLE_W      24
`define COUNT_W       10
`define COUNT_MAX     1023
`define SEQ_W         8

// seq, count hi, count lo, then three peak bytes
`define RECORD_BYTES  6

// ==========================================================
// register map, 12-bit byte offsets
// ==========================================================
`define ADDR_CTRL     12'h000
`define ADDR_STATUS   12'h008
`define ADDR_ERROR    12'h00C
`define ADDR_VERSION  12'h01C

`define VERSION_WORD  32'h0101_0000

`endif

// File: logic/enc_pkg.sv
// vector typedefs and packer state enum for the frame encoder
`include "enc_consts.svh"

package enc_pkg;

    // audio samples are two's complement
    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    // samples seen in one frame, saturating
    typedef logic [`COUNT_W-1:0] count_t;

    typedef logic [`SEQ_W-1:0] seq_t;

    // output stream byte
    typedef logic [7:0] byte_t;

    // register bus
    typedef logic [31:0] reg_word_t;
    typedef logic [11:0] reg_addr_t;

    // record packer FSM
    typedef enum logic {
        idle,
        send
    } pack_state_t;

endpackage

// File: logic/frame_peak_meter.sv
// per-frame peak absolute amplitude of the accepted samples
`timescale 1ns/1ps
`include "enc_consts.svh"

module frame_peak_meter (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             sample_accept,
    input  logic             frame_end,
    input  enc_pkg::sample_t audio_tdata,
    output enc_pkg::sample_t frame_peak
);
    import enc_pkg::*;

    localparam int MAG_W = `SAMPLE_W - 1;

    sample_t          neg_val;
    logic [MAG_W-1:0] mag;
    logic [MAG_W-1:0] run_max;
    logic [MAG_W-1:0] new_max;

    assign neg_val = -audio_tdata;

    // ==========================================================
    // absolute value
    // ==========================================================
    always_comb begin
        if (!audio_tdata[`SAMPLE_W-1]) begin
            mag = audio_tdata[MAG_W-1:0];
        end else if (audio_tdata[MAG_W-1:0] == '0) begin
            // most negative sample has no positive twin
            mag = '1;
        end else begin
            mag = neg_val[MAG_W-1:0];
        end
    end

    assign new_max = (mag > run_max) ? mag : run_max;

    // running max restarts after the tlast sample
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_max <= '0;
        end else if (frame_end) begin
            run_max <= '0;
        end else if (sample_accept) begin
            run_max <= new_max;
        end
    end

    // held for the packer until the next frame end
    always_ff @(posedge clk) begin
        if (frame_end) begin
            frame_peak <= sample_t'({1'b0, new_max});
        end
    end

endmodule

// File: logic/frame_record_packer.sv
// record packer FSM, six-byte frame record onto the byte stream
`timescale 1ns/1ps
`include "enc_consts.svh"

module frame_record_packer (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             frame_done,
    input  enc_pkg::count_t  frame_count,
    input  enc_pkg::sample_t frame_peak,
    input  logic             bs_tready,
    output logic             bs_tvalid,
    output enc_pkg::byte_t   bs_tdata,
    output logic             bs_tlast,
    output logic [15:0]      bs_tuser,
    output logic             packer_busy,
    output logic             record_sent
);
    import enc_pkg::*;

    localparam int IDX_W = $clog2(`RECORD_BYTES);

    pack_state_t      state;
    logic [IDX_W-1:0] byte_idx;
    seq_t             seq_num;
    seq_t             cap_seq;
    count_t           cap_count;
    sample_t          cap_peak;
    logic             byte_fire;
    logic             last_byte;

    assign bs_tvalid   = (state == send);
    assign packer_busy = bs_tvalid;
    assign byte_fire   = bs_tvalid && bs_tready;
    assign last_byte   = (byte_idx == IDX_W'(`RECORD_BYTES - 1));
    assign bs_tlast    = last_byte;
    assign record_sent = byte_fire && last_byte;
    assign bs_tuser    = {{(16 - `COUNT_W){1'b0}}, cap_count};

    // ==========================================================
    // FSM and byte pointer
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= idle;
            byte_idx <= '0;
            seq_num  <= '0;
        end else begin
            case (state)
                idle: begin
                    byte_idx <= '0;
                    if (frame_done) begin
                        state <= send;
                    end
                end
                send: begin
                    if (byte_fire) begin
                        if (last_byte) begin
                            state    <= idle;
                            byte_idx <= '0;
                            seq_num  <= seq_num + 1'b1;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // frame results, stable for the whole record
    always_ff @(posedge clk) begin
        if (state == idle && frame_done) begin
            cap_seq   <= seq_num;
            cap_count <= frame_count;
            cap_peak  <= frame_peak;
        end
    end

    // big-endian count and peak
    always_comb begin
        case (byte_idx)
            3'd0:    bs_tdata = byte_t'(cap_seq);
            3'd1:    bs_tdata = byte_t'(cap_count[`COUNT_W-1:8]);
            3'd2:    bs_tdata = cap_count[7:0];
            3'd3:    bs_tdata = cap_peak[23:16];
            3'd4:    bs_tdata = cap_peak[15:8];
            3'd5:    bs_tdata = cap_peak[7:0];
            default: bs_tdata = '0;
        endcase
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        bs_tvalid && !bs_tready |=> bs_tvalid && $stable(bs_tdata));

    // framer must hold input off while a record is in flight
    assert property (@(posedge clk) disable iff (!rst_n) frame_done |-> !packer_busy);

endmodule

// File: logic/sample_framer.sv
// input ready, sample counting, frame end, overlength and frame activity
`timescale 1ns/1ps
`include "enc_consts.svh"

module sample_framer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            ctrl_enable,
    input  logic            packer_busy,
    input  logic            audio_tvalid,
    input  logic            audio_tlast,
    output logic            audio_tready,
    output logic            sample_accept,
    output logic            frame_end,
    output logic            frame_done,
    output enc_pkg::count_t frame_count,
    output logic            frame_active,
    output logic            overlength
);
    import enc_pkg::*;

    count_t sample_cnt;
    count_t next_count;
    logic   cnt_at_max;

    // stall while the previous frame is handed over or still being sent
    assign audio_tready  = ctrl_enable && !packer_busy && !frame_done;
    assign sample_accept = audio_tvalid && audio_tready;
    assign frame_end     = sample_accept && audio_tlast;

    // count sticks at the top, extra samples only raise overlength
    assign cnt_at_max   = (sample_cnt == count_t'(`COUNT_MAX));
    assign next_count   = cnt_at_max ? sample_cnt : sample_cnt + 1'b1;
    assign overlength   = sample_accept && cnt_at_max;
    assign frame_active = (sample_cnt != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_cnt <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= frame_end;
            if (sample_accept) begin
                if (audio_tlast) begin
                    sample_cnt <= '0;
                end else begin
                    sample_cnt <= next_count;
                end
            end
        end
    end

    // finished count, including the tlast sample
    always_ff @(posedge clk) begin
        if (frame_end) begin
            frame_count <= next_count;
        end
    end

    // ready drops during frame_done, so frame ends are at least two cycles apart
    assert property (@(posedge clk) disable iff (!rst_n) frame_done |=> !frame_done);

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f files.f -o tb_sim

sim_out=$(./obj_dir/tb_sim)
echo "$sim_out"

if grep -qx "TEST PASS" <<< "$sim_out"; then
    exit 0
fi
exit 1

// File: testbench/tb_checker.sv
// stream monitor, expected frame records and byte-by-byte comparison
`timescale 1ns/1ps
`include "enc_consts.svh"

module tb_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        audio_tvalid,
    input  logic [31:0] audio_tdata,
    input  logic        audio_tlast,
    input  logic        audio_tready,
    input  logic        bs_tvalid,
    input  logic [7:0]  bs_tdata,
    input  logic        bs_tlast,
    input  logic [15:0] bs_tuser,
    input  logic        bs_tready,
    input  logic        encoding_active,
    input  logic        frame_processing,
    output int          err_count,
    output int          records_checked
);
    logic [7:0]  exp_bytes[$];
    logic [15:0] exp_user[$];
    int          frame_len;
    int          sat_len;
    int          byte_pos;
    int          rec_errs;
    logic [23:0] frame_max;
    logic [23:0] mag;
    logic [7:0]  next_seq;
    logic [7:0]  exp_byte;
    logic        done_cycle;
    logic        exp_busy;

    // magnitude of a signed 24-bit sample, most negative value clipped
    function automatic logic [23:0] abs_sample(input logic [23:0] s);
        logic [23:0] m;
        m = s[23] ? (~s + 24'd1) : s;
        if (m == 24'h800000) begin
            m = 24'h7fffff;
        end
        return m;
    endfunction

    task report_mismatch(input string sig, input logic [31:0] exp, input logic [31:0] got);
        $display("error: %s expected %h got %h (record %0d byte %0d)",
                 sig, exp, got, records_checked, byte_pos);
        err_count++;
        rec_errs++;
    endtask

    // seq, count big-endian, peak big-endian
    task queue_record();
        sat_len = (frame_len > `COUNT_MAX) ? `COUNT_MAX : frame_len;
        exp_bytes.push_back(next_seq);
        exp_bytes.push_back(8'(sat_len >> 8));
        exp_bytes.push_back(8'(sat_len));
        exp_bytes.push_back(frame_max[23:16]);
        exp_bytes.push_back(frame_max[15:8]);
        exp_bytes.push_back(frame_max[7:0]);
        exp_user.push_back(16'(sat_len));
        next_seq++;
        frame_len = 0;
        frame_max = '0;
    endtask

    task compare_byte();
        if (exp_bytes.size() == 0) begin
            $display("error: output byte appeared with no finished frame pending");
            err_count++;
            return;
        end
        exp_byte = exp_bytes.pop_front();
        if (bs_tdata !== exp_byte) report_mismatch("bs_tdata", exp_byte, bs_tdata);
        if (bs_tuser !== exp_user[0]) report_mismatch("bs_tuser", exp_user[0], bs_tuser);
        if (bs_tlast !== (byte_pos == `RECORD_BYTES - 1)) begin
            report_mismatch("bs_tlast", (byte_pos == `RECORD_BYTES - 1), bs_tlast);
        end
        byte_pos++;
        if (byte_pos == `RECORD_BYTES) begin
            $display("record %0d, %0d samples: %s", records_checked, exp_user[0],
                     (rec_errs == 0) ? "ok" : "mismatch");
            void'(exp_user.pop_front());
            records_checked++;
            byte_pos = 0;
            rec_errs = 0;
        end
    endtask

    initial begin
        err_count       = 0;
        records_checked = 0;
        frame_len       = 0;
        frame_max       = '0;
        next_seq        = '0;
        byte_pos        = 0;
        rec_errs        = 0;
        done_cycle      = 1'b0;
    end

    // handshakes sampled mid-cycle, the values hold until the next rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            // count is nonzero once a frame has taken its first sample
            if (frame_processing !== (frame_len != 0)) begin
                $display("error: frame_processing expected %h got %h",
                         (frame_len != 0), frame_processing);
                err_count++;
            end
            // busy from the cycle after frame_done up to the last byte
            exp_busy = (exp_bytes.size() != 0) && !done_cycle;
            if (encoding_active !== exp_busy) begin
                $display("error: encoding_active expected %h got %h",
                         exp_busy, encoding_active);
                err_count++;
            end
            done_cycle = 1'b0;
            if (audio_tvalid && audio_tready) begin
                if (encoding_active) begin
                    $display("error: audio sample accepted while a record was being sent");
                    err_count++;
                end
                mag = abs_sample(audio_tdata[23:0]);
                if (mag > frame_max) frame_max = mag;
                frame_len++;
                if (audio_tlast) begin
                    queue_record();
                    done_cycle = 1'b1;
                end
            end
            if (bs_tvalid && bs_tready) compare_byte();
        end
    end

endmodule

// File: testbench/tb_top.sv
// clock, reset, frame table, register access tasks and the DUT
`timescale 1ns/1ps
`include "enc_consts.svh"

module tb_top;
    localparam int NUM_ROWS     = 7;
    localparam int MODE_MIN_NEG = 1;
    localparam int MODE_MAX_POS = 2;
    localparam int WAIT_LIMIT   = 400;

    // ==========================================================
    // frame table: length, sample mode, sparse output ready
    // ==========================================================
    localparam int ROW_LEN   [0:NUM_ROWS-1] = '{1, 6, 17, 4, 1030, 9, 2};
    localparam int ROW_MODE  [0:NUM_ROWS-1] = '{0, 1, 0, 2, 0, 1, 0};
    localparam bit ROW_THIRD [0:NUM_ROWS-1] = '{0, 0, 1, 1, 0, 1, 0};

    logic clk, rst_n, audio_tvalid, audio_tlast, audio_tready;
    logic bs_tvalid, bs_tlast, psel, penable, pwrite, pready, pslverr;
    logic encoding_active, frame_processing, ready_seen, rd_err;
    logic bs_tready = 1'b0;
    logic [7:0]  bs_tdata;
    logic [15:0] bs_tuser;
    logic [11:0] paddr;
    logic [31:0] audio_tdata, pwdata, prdata, error_status, rd_data;
    logic [31:0] sample_state, ready_state;
    bit          ready_third;
    int          tb_errs, tb_tests, chk_errs, chk_records;

    audio_frame_encoder_top audio_frame_encoder_top_inst (.*);

    tb_checker tb_checker_inst (
        .clk(clk), .rst_n(rst_n), .audio_tvalid(audio_tvalid), .audio_tdata(audio_tdata),
        .audio_tlast(audio_tlast), .audio_tready(audio_tready), .bs_tvalid(bs_tvalid),
        .bs_tdata(bs_tdata), .bs_tlast(bs_tlast), .bs_tuser(bs_tuser), .bs_tready(bs_tready),
        .encoding_active(encoding_active), .frame_processing(frame_processing),
        .err_count(chk_errs), .records_checked(chk_records)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task abort_run(input string why);
        $display("timeout: %s", why);
        $display("TEST FAIL");
        $finish;
    endtask

    task check_value(input string test, input string sig, input logic [31:0] got,
                     input logic [31:0] exp);
        tb_tests++;
        if (got !== exp) begin
            $display("error: %s expected %h got %h", sig, exp, got);
            $display("%s: failed", test);
            tb_errs++;
        end else begin
            $display("%s: ok", test);
        end
    endtask

    // setup cycle, then access until pready
    task bus_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata);
        int waited;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #10 penable = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!pready) begin
            waited++;
            if (waited > WAIT_LIMIT) abort_run("pready never rose");
            @(negedge clk);
        end
        rd_data = prdata;
        rd_err  = pslverr;
        @(posedge clk);
        #10 psel = 1'b0;
        penable = 1'b0;
    endtask

    task send_sample(input logic [31:0] data, input logic last);
        int waited;
        audio_tvalid = 1'b1;
        audio_tdata  = data;
        audio_tlast  = last;
        waited = 0;
        @(negedge clk);
        while (!audio_tready) begin
            waited++;
            if (waited > WAIT_LIMIT) abort_run("audio_tready stayed low");
            @(negedge clk);
        end
        @(posedge clk);
        #10 audio_tvalid = 1'b0;
        audio_tlast = 1'b0;
    endtask

    task send_frame(input int len, input int mode);
        logic [31:0] data;
        for (int i = 0; i < len; i++) begin
            sample_state = xorshift32(sample_state);
            data = sample_state;
            // 20-bit random amplitude so the forced extremes stand out
            data[23:0] = {{4{sample_state[19]}}, sample_state[19:0]};
            if (i == len / 2 && mode == MODE_MIN_NEG) data[23:0] = 24'h800000;
            if (i == len / 2 && mode == MODE_MAX_POS) data[23:0] = 24'h7fffff;
            send_sample(data, i == len - 1);
        end
    endtask

    task wait_records(input int n);
        int waited;
        waited = 0;
        while (chk_records < n) begin
            waited++;
            if (waited > WAIT_LIMIT) abort_run("frame record never left the byte stream");
            @(posedge clk);
            #10;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // output back-pressure, pattern chosen per table row
    always @(posedge clk) begin
        #10;
        if (ready_third) begin
            ready_state = xorshift32(ready_state);
            bs_tready = (ready_state % 3 == 0);
        end else begin
            bs_tready = 1'b1;
        end
    end

    initial begin
        {rst_n, audio_tvalid, audio_tlast, psel, penable, pwrite} = '0;
        {audio_tdata, pwdata, paddr} = '0;
        {tb_errs, tb_tests} = '0;
        ready_third  = 1'b0;
        sample_state = 32'hfe7ed9c4;
        ready_state  = 32'hfe7ed9c4;
        repeat (5) @(posedge clk);
        #10 rst_n = 1'b1;

        bus_access(1'b0, `ADDR_VERSION, '0);
        check_value("version read", "prdata", rd_data, `VERSION_WORD);
        bus_access(1'b0, `ADDR_STATUS, '0);
        check_value("status after reset", "prdata", rd_data, '0);
        bus_access(1'b0, 12'h004, '0);
        check_value("unmapped read", "pslverr", rd_err, 1);

        // encoder still disabled, input must be refused
        ready_seen   = 1'b0;
        audio_tvalid = 1'b1;
        repeat (8) begin
            @(negedge clk);
            ready_seen = ready_seen | audio_tready;
        end
        @(posedge clk);
        #10 audio_tvalid = 1'b0;
        check_value("input held off while disabled", "audio_tready", ready_seen, 0);
        bus_access(1'b1, `ADDR_CTRL, 32'h1);
        check_value("enable write", "pslverr", rd_err, 0);

        // frames back to back, the next one is offered while a record is still leaving
        for (int r = 0; r < NUM_ROWS; r++) begin
            ready_third = ROW_THIRD[r];
            send_frame(ROW_LEN[r], ROW_MODE[r]);
            if (ROW_LEN[r] > `COUNT_MAX) begin
                wait_records(r + 1);
                bus_access(1'b0, `ADDR_ERROR, '0);
                check_value("overlength flag set", "prdata", rd_data, 32'h1);
                check_value("overlength output set", "error_status", error_status, 32'h1);
                bus_access(1'b1, `ADDR_ERROR, 32'h1);
                bus_access(1'b0, `ADDR_ERROR, '0);
                check_value("overlength flag cleared", "prdata", rd_data, '0);
                check_value("overlength output cleared", "error_status", error_status, '0);
            end
        end
        wait_records(NUM_ROWS);

        bus_access(1'b0, `ADDR_STATUS, '0);
        check_value("records counted", "prdata", rd_data, NUM_ROWS);

        $display("%0d tests, %0d errors", tb_tests + chk_records, tb_errs + chk_errs);
        if (tb_errs + chk_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
